/* ex_unit.f */
ex_pkg.sv
ex_alu.sv
ex_multdiv_slow.sv
ex_block.sv
ex_op_fifo.sv
ex_issue.sv
ex_unit_top.sv
tb_ex_unit_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f ex_unit.f --top-module tb_ex_unit_top -o sim_ex_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_ex_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF ">>> PASS" <<< "$output"; then
	exit 0
fi
exit 1

/* tb_ex_unit_top.sv */
`timescale 1ns/1ns

module tb_ex_unit_top;
	import ex_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 16;
	localparam int N_RANDOM = 300;
	localparam int N_DIRECTED_MAX = 100;   // upper bound on the directed operations.
	localparam int TIMEOUT_CYCLES = RST_CYCLES + 40 * (N_RANDOM + N_DIRECTED_MAX) + 500;
	localparam logic [31:0] SEED = 32'hc0b92b52;

	logic    clk = 1'b0;
	logic    rst;
	logic    op_valid;
	ex_op_t  op;
	logic    res_valid;
	ex_res_t res;

	ex_res_t expected [$];
	ex_res_t exp_res;
	int      issued = 0;
	int      results_seen = 0;
	int      value_errors = 0;
	int      other_errors = 0;
	int      checks = 0;

	// -7/3, overflow, divide by zero and two large values.
	logic [XLEN-1:0] md_a [4] = '{32'hffff_fff9, 32'h8000_0000, 32'h0000_0005, 32'hffff_fffe};
	logic [XLEN-1:0] md_b [4] = '{32'h0000_0003, 32'hffff_ffff, 32'h0000_0000, 32'hffff_fffd};
	logic [11:0]     bt_imms [4] = '{12'h800, 12'hfff, 12'h7ff, 12'h001};

	ex_unit_top UUT (
		.clk_i       (clk),
		.rst_i       (rst),
		.op_valid_i  (op_valid),
		.op_i        (op),
		.res_valid_o (res_valid),
		.res_o       (res)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// expected result from the RV32IM rules for one operation.
	function automatic ex_res_t model_result(input ex_op_t o);
		ex_res_t         r;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] adder;
		int              bt_off;
		longint          va;
		longint          vb;
		longint          full;
		longint          quot;
		longint          rem;
		a = o.operand_a;
		b = o.operand_b;
		r = '0;
		r.tag = o.tag;
		adder = (o.alu_operator inside {ALU_SUB, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_SLT,
			ALU_SLTU}) ? a - b : a + b;
		case (o.alu_operator)
			ALU_LT, ALU_SLT:   r.branch_decision = $signed(a) < $signed(b);
			ALU_LTU, ALU_SLTU: r.branch_decision = a < b;
			ALU_GE:            r.branch_decision = $signed(a) >= $signed(b);
			ALU_GEU:           r.branch_decision = a >= b;
			ALU_EQ:            r.branch_decision = a == b;
			ALU_NE:            r.branch_decision = a != b;
			default:           r.branch_decision = 1'b0;
		endcase
		case (o.alu_operator)
			ALU_ADD, ALU_SUB: r.wdata = adder;
			ALU_XOR:          r.wdata = a ^ b;
			ALU_OR:           r.wdata = a | b;
			ALU_AND:          r.wdata = a & b;
			ALU_SRA:          r.wdata = $signed(a) >>> b[4:0];
			ALU_SRL:          r.wdata = a >> b[4:0];
			ALU_SLL:          r.wdata = a << b[4:0];
			default:          r.wdata = {{(XLEN-1){1'b0}}, r.branch_decision};
		endcase
		if (o.is_md) begin
			va = o.signed_mode[0] ? longint'($signed(a)) : longint'(a);
			vb = o.signed_mode[1] ? longint'($signed(b)) : longint'(b);
			full = va * vb;
			quot = (vb == 0) ? -1 : va / vb;
			rem = (vb == 0) ? va : va % vb;
			case (o.md_operator)
				MD_OP_MULL: r.wdata = full[XLEN-1:0];
				MD_OP_MULH: r.wdata = full[2*XLEN-1:XLEN];
				MD_OP_DIV:  r.wdata = quot[XLEN-1:0];
				default:    r.wdata = rem[XLEN-1:0];
			endcase
		end
		bt_off = 2 * $signed(o.bt_imm);   // byte offset of a halfword immediate.
		r.jump_target = (o.jt_sel == JT_ALU) ? adder : o.pc + XLEN'(bt_off);
		return r;
	endfunction

	function automatic logic [XLEN-1:0] rand_operand();
		case ($urandom() % 8)
			0:       return '0;
			1:       return 32'h8000_0000;
			2:       return '1;
			3:       return 32'h0000_0001;
			default: return $urandom();
		endcase
	endfunction

	function automatic ex_op_t make_op(input logic is_md, input alu_op_e aop, input md_op_e mop,
		input logic [1:0] mode, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		ex_op_t o;
		o = '0;
		o.is_md = is_md;
		o.alu_operator = aop;
		o.md_operator = mop;
		o.signed_mode = mode;
		o.operand_a = a;
		o.operand_b = b;
		o.pc = $urandom();
		o.bt_imm = 12'($urandom());
		o.jt_sel = ($urandom() % 2 == 0) ? JT_ALU : JT_BT_ALU;
		return o;
	endfunction

	function automatic ex_op_t alu_op(input alu_op_e aop, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		return make_op(1'b0, aop, MD_OP_MULL, 2'b00, a, b);
	endfunction

	function automatic ex_op_t random_op();
		logic is_md;
		is_md = ($urandom() % 10) < 3;
		return make_op(is_md, is_md ? ALU_ADD : alu_op_e'(5'($urandom() % 16)),
			md_op_e'(2'($urandom() % 4)), 2'($urandom()), rand_operand(), rand_operand());
	endfunction

	// holds off while the queue could overflow.
	task automatic push_op(input ex_op_t o);
		ex_op_t t;
		t = o;
		t.tag = TAG_W'(issued);
		@(posedge clk);
		while (issued - results_seen >= FIFO_DEPTH) begin
			op_valid <= 1'b0;
			@(posedge clk);
		end
		op_valid <= 1'b1;
		op <= t;
		expected.push_back(model_result(t));
		issued++;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		op_valid <= 1'b0;
	endtask

	task automatic check_field(input string what, input int tag, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		checks++;
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t ns: tag %0d %s is %h, expected %h", $time, tag, what, got, want);
		end
	endtask

	always @(posedge clk) begin
		if (!rst && res_valid) begin
			if (expected.size() == 0) begin
				other_errors++;
				$display("result strobe at %0t ns with no operation outstanding", $time);
			end else begin
				exp_res = expected.pop_front();
				check_field("tag", exp_res.tag, res.tag, exp_res.tag);
				check_field("wdata", exp_res.tag, res.wdata, exp_res.wdata);
				check_field("jump target", exp_res.tag, res.jump_target, exp_res.jump_target);
				check_field("branch", exp_res.tag, res.branch_decision, exp_res.branch_decision);
				results_seen <= results_seen + 1;
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: results still missing after %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int     i;
		int     m;
		ex_op_t o;
		void'($urandom(SEED));
		rst = 1'b1;
		op_valid = 1'b0;
		op = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (20) @(posedge clk);   // any strobe here is flagged by the checker.
		push_op(alu_op(ALU_ADD, 32'h7fff_ffff, 32'h0000_0001));
		push_op(alu_op(ALU_SUB, 32'h0000_0000, 32'h0000_0001));
		push_op(alu_op(ALU_XOR, 32'ha5a5_a5a5, 32'h0f0f_0f0f));
		push_op(alu_op(ALU_OR, 32'ha5a5_a5a5, 32'h0f0f_0f0f));
		push_op(alu_op(ALU_AND, 32'ha5a5_a5a5, 32'h0f0f_0f0f));
		push_op(alu_op(ALU_SRA, 32'h8000_0000, 32'd31));
		push_op(alu_op(ALU_SRA, 32'hf000_0000, 32'd36));
		push_op(alu_op(ALU_SRL, 32'hf000_0000, 32'd36));
		push_op(alu_op(ALU_SLL, 32'h0000_0001, 32'd33));
		push_op(alu_op(ALU_SLL, 32'hdead_beef, 32'd0));
		push_op(alu_op(ALU_LT, 32'hffff_ffff, 32'h0000_0001));
		push_op(alu_op(ALU_LTU, 32'hffff_ffff, 32'h0000_0001));
		push_op(alu_op(ALU_GE, 32'h0000_0005, 32'h0000_0005));
		push_op(alu_op(ALU_GEU, 32'h0000_0001, 32'hffff_ffff));
		push_op(alu_op(ALU_EQ, 32'h0000_1234, 32'h0000_1234));
		push_op(alu_op(ALU_NE, 32'h0000_1234, 32'h0000_1234));
		push_op(alu_op(ALU_SLT, 32'h8000_0000, 32'h7fff_ffff));
		push_op(alu_op(ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff));
		for (i = 0; i < 4; i++) begin
			o = alu_op(ALU_SUB, $urandom(), $urandom());
			o.jt_sel = (i == 3) ? JT_ALU : JT_BT_ALU;
			o.bt_imm = bt_imms[i];
			push_op(o);
		end
		for (m = 0; m < 4; m++) begin
			for (i = 0; i < 16; i++) begin
				push_op(make_op(1'b1, ALU_ADD, md_op_e'(2'(i % 4)), 2'(m), md_a[i / 4],
					md_b[i / 4]));
			end
		end
		for (i = 0; i < N_RANDOM; i++) begin
			push_op(random_op());
			if ($urandom() % 16 == 0) begin
				idle_cycle();
			end
		end
		idle_cycle();
		while (results_seen < issued) @(posedge clk);
		repeat (10) @(posedge clk);
		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* ex_unit_top.sv */
`timescale 1ns/1ns

module ex_unit_top (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             op_valid_i,
	input  ex_pkg::ex_op_t   op_i,
	output logic             res_valid_o,
	output ex_pkg::ex_res_t  res_o
);
	import ex_pkg::*;

	ex_op_t          head;
	ex_op_t          cur_op;
	logic            empty;
	logic            pop;
	logic            md_start;
	logic [XLEN-1:0] wdata;
	logic [XLEN-1:0] jump_target;
	logic            branch_decision;
	logic            ex_valid;

	ex_op_fifo op_fifo_i (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (op_valid_i),
		.data_i  (op_i),
		.pop_i   (pop),
		.head_o  (head),
		.empty_o (empty)
	);

	ex_issue issue_i (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.head_i            (head),
		.empty_i           (empty),
		.pop_o             (pop),
		.cur_op_o          (cur_op),
		.md_start_o        (md_start),
		.wdata_i           (wdata),
		.jump_target_i     (jump_target),
		.branch_decision_i (branch_decision),
		.ex_valid_i        (ex_valid),
		.res_valid_o       (res_valid_o),
		.res_o             (res_o)
	);

	ex_block ex_block_i (
		.clk_i              (clk_i),
		.rst_i              (rst_i),
		.op_i               (cur_op),
		.md_start_i         (md_start),
		.regfile_wdata_ex_o (wdata),
		.jump_target_o      (jump_target),
		.branch_decision_o  (branch_decision),
		.ex_valid_o         (ex_valid)
	);

endmodule

/* ex_issue.sv */
`timescale 1ns/1ns

module ex_issue (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  ex_pkg::ex_op_t            head_i,
	input  logic                      empty_i,
	output logic                      pop_o,
	output ex_pkg::ex_op_t            cur_op_o,
	output logic                      md_start_o,
	input  logic [ex_pkg::XLEN-1:0]   wdata_i,
	input  logic [ex_pkg::XLEN-1:0]   jump_target_i,
	input  logic                      branch_decision_i,
	input  logic                      ex_valid_i,
	output logic                      res_valid_o,
	output ex_pkg::ex_res_t           res_o
);
	import ex_pkg::*;

	logic   busy_q;
	logic   first_q;   // first cycle the operation is held.
	logic   finish;
	ex_op_t cur_op_q;

	assign pop_o = ~busy_q & ~empty_i;
	assign finish = busy_q & ex_valid_i;
	assign cur_op_o = cur_op_q;
	assign md_start_o = first_q & cur_op_q.is_md;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q      <= 1'b0;
			first_q     <= 1'b0;
			res_valid_o <= 1'b0;
		end else begin
			first_q     <= pop_o;
			res_valid_o <= finish;
			if (pop_o) begin
				busy_q <= 1'b1;
			end else if (finish) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			cur_op_q <= head_i;
		end
		if (finish) begin
			res_o.tag             <= cur_op_q.tag;
			res_o.wdata           <= wdata_i;
			res_o.jump_target     <= jump_target_i;
			res_o.branch_decision <= branch_decision_i;
		end
	end

endmodule

/* ex_op_fifo.sv */
`timescale 1ns/1ns

module ex_op_fifo (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            push_i,
	input  ex_pkg::ex_op_t  data_i,
	input  logic            pop_i,
	output ex_pkg::ex_op_t  head_o,
	output logic            empty_o
);
	import ex_pkg::*;

	ex_op_t                          mem_q [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
	logic [$clog2(FIFO_DEPTH):0]     count_q;
	logic                            full;

	assign empty_o = (count_q == '0);
	assign full = (count_q == FIFO_DEPTH);
	assign head_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;   // depth is a power of two, pointers wrap.
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

	a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
		push_i |-> !full)
		else $error("operation pushed into a full queue");

	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("pop from an empty queue");

endmodule

/* ex_block.sv */
`timescale 1ns/1ns

module ex_block (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  ex_pkg::ex_op_t            op_i,
	input  logic                      md_start_i,
	output logic [ex_pkg::XLEN-1:0]   regfile_wdata_ex_o,
	output logic [ex_pkg::XLEN-1:0]   jump_target_o,
	output logic                      branch_decision_o,
	output logic                      ex_valid_o
);
	import ex_pkg::*;

	logic [XLEN-1:0] alu_adder_result;
	logic [XLEN-1:0] alu_result;
	logic            alu_cmp_result;
	logic [XLEN-1:0] multdiv_result;
	logic            multdiv_valid;
	logic [XLEN-1:0] bt_result;

	ex_alu alu_i (
		.operator_i          (op_i.alu_operator),
		.operand_a_i         (op_i.operand_a),
		.operand_b_i         (op_i.operand_b),
		.adder_result_o      (alu_adder_result),
		.result_o            (alu_result),
		.comparison_result_o (alu_cmp_result)
	);

	ex_multdiv_slow multdiv_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.start_i       (md_start_i),
		.operator_i    (op_i.md_operator),
		.signed_mode_i (op_i.signed_mode),
		.op_a_i        (op_i.operand_a),
		.op_b_i        (op_i.operand_b),
		.valid_o       (multdiv_valid),
		.result_o      (multdiv_result)
	);

	// branch offsets are in halfwords.
	assign bt_result = op_i.pc + {{(XLEN-13){op_i.bt_imm[11]}}, op_i.bt_imm, 1'b0};

	assign regfile_wdata_ex_o = op_i.is_md ? multdiv_result : alu_result;
	assign jump_target_o = (op_i.jt_sel == JT_ALU) ? alu_adder_result : bt_result;
	assign branch_decision_o = alu_cmp_result;
	assign ex_valid_o = op_i.is_md ? multdiv_valid : 1'b1;

endmodule

/* ex_multdiv_slow.sv */
`timescale 1ns/1ns

module ex_multdiv_slow (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      start_i,
	input  ex_pkg::md_op_e            operator_i,
	input  logic [1:0]                signed_mode_i,
	input  logic [ex_pkg::XLEN-1:0]   op_a_i,
	input  logic [ex_pkg::XLEN-1:0]   op_b_i,
	output logic                      valid_o,
	output logic [ex_pkg::XLEN-1:0]   result_o
);
	import ex_pkg::*;

	logic            busy_q;
	logic            done_q;
	logic [4:0]      cnt_q;
	logic            iter;

	logic            sign_a;
	logic            sign_b;
	logic [XLEN-1:0] abs_a;
	logic [XLEN-1:0] abs_b;

	logic [XLEN-1:0] hi_q;          // partial product high word or remainder.
	logic [XLEN-1:0] lo_q;          // multiplier bits or dividend/quotient bits.
	logic [XLEN-1:0] op_b_q;
	md_op_e          operator_q;
	logic            sign_a_q;
	logic            sign_b_q;
	logic            div_zero_q;
	logic            is_div;

	logic [XLEN:0]     add_a;
	logic [XLEN:0]     add_b;
	logic [XLEN+1:0]   add_res;
	logic [XLEN:0]     mult_hi;
	logic [2*XLEN-1:0] prod_mag;
	logic [2*XLEN-1:0] prod_res;

	assign sign_a = signed_mode_i[0] & op_a_i[XLEN-1];
	assign sign_b = signed_mode_i[1] & op_b_i[XLEN-1];
	assign abs_a = sign_a ? -op_a_i : op_a_i;
	assign abs_b = sign_b ? -op_b_i : op_b_i;

	assign iter = busy_q & ~done_q;
	assign is_div = operator_q inside {MD_OP_DIV, MD_OP_REM};

	// one adder, add for multiply and subtract with carry-in for divide.
	assign add_a = is_div ? {hi_q, lo_q[XLEN-1]} : {1'b0, hi_q};
	assign add_b = is_div ? ~{1'b0, op_b_q} : {1'b0, op_b_q};
	assign add_res = {1'b0, add_a} + {1'b0, add_b} + {{(XLEN+1){1'b0}}, is_div};
	assign mult_hi = lo_q[0] ? add_res[XLEN:0] : {1'b0, hi_q};

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end else if (iter) begin
				cnt_q <= cnt_q + 5'd1;
				if (cnt_q == 5'd31) begin
					done_q <= 1'b1;
				end
			end else if (done_q) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			hi_q       <= '0;
			lo_q       <= abs_a;
			op_b_q     <= abs_b;
			operator_q <= operator_i;
			sign_a_q   <= sign_a;
			sign_b_q   <= sign_b;
			div_zero_q <= (op_b_i == '0);
		end else if (iter) begin
			if (is_div) begin
				hi_q <= add_res[XLEN+1] ? add_res[XLEN-1:0] : {hi_q[XLEN-2:0], lo_q[XLEN-1]};
				lo_q <= {lo_q[XLEN-2:0], add_res[XLEN+1]};   // carry out means no borrow.
			end else begin
				hi_q <= mult_hi[XLEN:1];
				lo_q <= {mult_hi[0], lo_q[XLEN-1:1]};
			end
		end
	end

	assign prod_mag = {hi_q, lo_q};
	assign prod_res = (sign_a_q ^ sign_b_q) ? -prod_mag : prod_mag;

	// most negative / -1 needs no special case, the magnitudes already give it.
	always_comb begin
		case (operator_q)
			MD_OP_MULL: result_o = prod_res[XLEN-1:0];
			MD_OP_MULH: result_o = prod_res[2*XLEN-1:XLEN];
			MD_OP_DIV:  result_o = div_zero_q ? '1 : ((sign_a_q ^ sign_b_q) ? -lo_q : lo_q);
			default:    result_o = sign_a_q ? -hi_q : hi_q;   // remainder takes the dividend sign.
		endcase
	end

	assign valid_o = done_q;

	a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		start_i |-> !busy_q)
		else $error("multdiv started while an operation is in flight");

endmodule

/* ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
	input  ex_pkg::alu_op_e           operator_i,
	input  logic [ex_pkg::XLEN-1:0]   operand_a_i,
	input  logic [ex_pkg::XLEN-1:0]   operand_b_i,
	output logic [ex_pkg::XLEN-1:0]   adder_result_o,
	output logic [ex_pkg::XLEN-1:0]   result_o,
	output logic                      comparison_result_o
);
	import ex_pkg::*;

	logic            adder_negate;
	logic            cmp_signed;
	logic [XLEN:0]   adder_in_a;
	logic [XLEN:0]   adder_in_b;
	logic [XLEN+1:0] adder_sum;
	logic            is_less;
	logic            is_equal;

	logic                   shift_left;
	logic                   shift_arith;
	logic [4:0]             shamt;
	logic [XLEN-1:0]        operand_a_rev;
	logic [XLEN-1:0]        shift_operand;
	logic signed [XLEN:0]   shift_ext;
	logic [XLEN:0]          shift_right_ext;
	logic [XLEN-1:0]        shift_right;
	logic [XLEN-1:0]        shift_right_rev;
	logic [XLEN-1:0]        shift_result;

	assign adder_negate = (operator_i == ALU_SUB) ||
		(operator_i inside {ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_SLT, ALU_SLTU});
	assign cmp_signed = operator_i inside {ALU_LT, ALU_GE, ALU_SLT};

	// 33-bit operands so bit 32 of the difference is the less-than flag.
	assign adder_in_a = {cmp_signed & operand_a_i[XLEN-1], operand_a_i};
	assign adder_in_b = {cmp_signed & operand_b_i[XLEN-1], operand_b_i};
	assign adder_sum = {adder_in_a, 1'b1} +
		{(adder_negate ? ~adder_in_b : adder_in_b), adder_negate}; // lsb pair is the carry-in.
	assign adder_result_o = adder_sum[XLEN:1];
	assign is_less = adder_sum[XLEN+1];
	assign is_equal = ~|(operand_a_i ^ operand_b_i);

	always_comb begin
		case (operator_i)
			ALU_LT, ALU_LTU, ALU_SLT, ALU_SLTU: comparison_result_o = is_less;
			ALU_GE, ALU_GEU:                    comparison_result_o = ~is_less;
			ALU_EQ:                             comparison_result_o = is_equal;
			ALU_NE:                             comparison_result_o = ~is_equal;
			default:                            comparison_result_o = 1'b0;
		endcase
	end

	// left shifts reuse the right shifter on the reversed operand.
	assign shift_left = (operator_i == ALU_SLL);
	assign shift_arith = (operator_i == ALU_SRA);
	assign shamt = operand_b_i[4:0];
	assign operand_a_rev = {<<{operand_a_i}};
	assign shift_operand = shift_left ? operand_a_rev : operand_a_i;
	assign shift_ext = {shift_arith & operand_a_i[XLEN-1], shift_operand};
	assign shift_right_ext = shift_ext >>> shamt;
	assign shift_right = shift_right_ext[XLEN-1:0];
	assign shift_right_rev = {<<{shift_right}};
	assign shift_result = shift_left ? shift_right_rev : shift_right;

	always_comb begin
		case (operator_i)
			ALU_ADD, ALU_SUB:          result_o = adder_result_o;
			ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
			ALU_OR:                    result_o = operand_a_i | operand_b_i;
			ALU_AND:                   result_o = operand_a_i & operand_b_i;
			ALU_SRA, ALU_SRL, ALU_SLL: result_o = shift_result;
			default:                   result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
		endcase
	end

endmodule

/* ex_pkg.sv */
package ex_pkg;

	localparam int XLEN = 32;
	localparam int TAG_W = 4;
	localparam int FIFO_DEPTH = 8;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_SUB  = 5'd1,
		ALU_XOR  = 5'd2,
		ALU_OR   = 5'd3,
		ALU_AND  = 5'd4,
		ALU_SRA  = 5'd5,
		ALU_SRL  = 5'd6,
		ALU_SLL  = 5'd7,
		ALU_LT   = 5'd8,
		ALU_LTU  = 5'd9,
		ALU_GE   = 5'd10,
		ALU_GEU  = 5'd11,
		ALU_EQ   = 5'd12,
		ALU_NE   = 5'd13,
		ALU_SLT  = 5'd14,
		ALU_SLTU = 5'd15
	} alu_op_e;

	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	typedef enum logic [0:0] {
		JT_ALU    = 1'b0,
		JT_BT_ALU = 1'b1
	} jt_sel_e;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             is_md;        // route to the multiplier/divider.
		alu_op_e          alu_operator;
		md_op_e           md_operator;
		logic [1:0]       signed_mode;  // bit 0 for a, bit 1 for b.
		logic [XLEN-1:0]  operand_a;
		logic [XLEN-1:0]  operand_b;
		logic [XLEN-1:0]  pc;
		logic [11:0]      bt_imm;
		jt_sel_e          jt_sel;
	} ex_op_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  wdata;
		logic [XLEN-1:0]  jump_target;
		logic             branch_decision;
	} ex_res_t;

endpackage
